//--- cache.f
hdl/cache_pkg.sv
hdl/cache_ctrl.sv
hdl/cache_meta.sv
hdl/cache_dpath.sv
hdl/cache_top.sv
tb/cache_tb_mem.sv
tb/cache_tb.sv

//--- hdl/cache_ctrl.sv
/*
 * cache controller: FSM sequencing tag check, hits, evict and refill,
 * and the per-state control decode for metadata and datapath
 */
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl
  import cache_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        reset,
  input  wire logic        req_val,
  input  wire logic        resp_rdy,
  input  wire logic        mem_req_rdy,
  input  wire logic        mem_resp_val,
  input  wire req_type_e   req_type,
  input  wire logic        hit,
  input  wire logic        victim_dirty,
  output logic             req_rdy,
  output logic             resp_val,
  output logic             mem_req_val,
  output logic             mem_resp_rdy,
  output way_ctrl_t        ctl,
  output ctrl_state_e      state
);

  ctrl_state_e state_next;
  logic        is_read;
  logic        is_write;
  logic        is_init;

  assign is_read  = (req_type == req_read);
  assign is_write = (req_type == req_write);
  assign is_init  = (req_type == req_init);

  // ---------------------------------------------------------------------
  // state register and transitions
  // ---------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      st_idle:
        if (req_val) state_next = st_tag_check;
      st_tag_check: begin
        if (is_init) begin
          state_next = st_init_wr;
        end else if (hit && is_read) begin
          // read hit may chain straight into the next tag check
          if (resp_rdy && req_val) state_next = st_tag_check;
          else if (resp_rdy)       state_next = st_idle;
          else                     state_next = st_resp_wait;
        end else if (hit) begin
          state_next = resp_rdy ? st_hit_wr_sent : st_hit_wr_wait;
        end else begin
          state_next = victim_dirty ? st_evict_prep : st_refill_req;
        end
      end
      st_init_wr: begin
        if (resp_rdy && req_val) state_next = st_tag_check;
        else if (resp_rdy)       state_next = st_idle;
        else                     state_next = st_resp_wait;
      end
      st_hit_wr_sent:
        state_next = req_val ? st_tag_check : st_idle;
      st_hit_wr_wait: begin
        if (resp_rdy && req_val) state_next = st_tag_check;
        else if (resp_rdy)       state_next = st_idle;
      end
      st_resp_wait:
        if (resp_rdy) state_next = st_idle;
      st_refill_req:
        if (mem_req_rdy) state_next = st_refill_wait;
      st_refill_wait:
        if (mem_resp_val) state_next = st_refill_update;
      st_refill_update:
        state_next = is_read ? st_miss_rd : st_miss_wr;
      st_evict_prep:
        state_next = st_evict_req;
      st_evict_req:
        if (mem_req_rdy) state_next = st_evict_wait;
      st_evict_wait:
        if (mem_resp_val) state_next = st_refill_req;
      st_miss_rd,
      st_miss_wr:
        state_next = st_resp_wait;
      default:
        state_next = st_idle;
    endcase
  end

  // ---------------------------------------------------------------------
  // per-state control decode
  // ---------------------------------------------------------------------

  always_comb begin
    ctl          = '0;
    req_rdy      = 1'b0;
    mem_req_val  = 1'b0;
    mem_resp_rdy = 1'b0;
    case (state)
      st_idle: begin
        req_rdy     = 1'b1;
        ctl.idx_sel = 1'b1;
      end
      st_tag_check: begin
        ctl.tc_en  = 1'b1;
        ctl.rd_en  = 1'b1;
        ctl.rd_byp = 1'b1;
        if (is_init) begin
          // init always lands in way 0 as a clean line
          ctl.tag_we   = 1'b1;
          ctl.data_we  = 1'b1;
          ctl.dirty_we = 1'b1;
        end else if (hit && is_read) begin
          ctl.use_we = 1'b1;
          req_rdy    = resp_rdy;
        end else if (hit) begin
          ctl.data_we   = 1'b1;
          ctl.dirty_we  = 1'b1;
          ctl.dirty_val = 1'b1;
          ctl.use_we    = 1'b1;
        end
      end
      st_init_wr: begin
        ctl.use_we = 1'b1;
        req_rdy    = resp_rdy;
      end
      st_hit_wr_sent:   req_rdy = 1'b1;
      st_hit_wr_wait:   req_rdy = resp_rdy;
      st_refill_req:    mem_req_val = 1'b1;
      st_refill_wait: begin
        mem_resp_rdy  = 1'b1;
        ctl.refill_en = mem_resp_val;
      end
      st_refill_update: begin
        ctl.tag_we    = 1'b1;
        ctl.data_we   = 1'b1;
        ctl.wdata_sel = 1'b1;
        ctl.dirty_we  = 1'b1;
        ctl.dirty_val = is_write;
      end
      st_evict_prep:    ctl.evict_en = 1'b1;
      st_evict_req: begin
        mem_req_val   = 1'b1;
        ctl.maddr_sel = 1'b1;
      end
      st_evict_wait:    mem_resp_rdy = 1'b1;
      st_miss_rd: begin
        ctl.rd_en  = 1'b1;
        ctl.use_we = 1'b1;
      end
      st_miss_wr:       ctl.use_we = 1'b1;
      default: ;
    endcase
    // register the request only on a real transfer
    ctl.req_en = req_rdy && req_val;
  end

  // response valid from state, hit and type only, never from resp_rdy
  always_comb begin
    resp_val = (state == st_init_wr) || (state == st_hit_wr_wait) ||
               (state == st_resp_wait);
    if (state == st_tag_check && hit && !is_init) resp_val = 1'b1;
  end

  // memory and processor are never served in the same cycle
  a_mem_resp_excl: assert property (@(posedge clk) disable iff (reset)
    !(mem_req_val && resp_val));

  a_state_legal: assert property (@(posedge clk) disable iff (reset)
    state inside {st_idle, st_tag_check, st_init_wr, st_hit_wr_sent,
                  st_hit_wr_wait, st_resp_wait, st_refill_req, st_refill_wait,
                  st_refill_update, st_evict_prep, st_evict_req, st_evict_wait,
                  st_miss_rd, st_miss_wr});

endmodule

`default_nettype wire

//--- hdl/cache_dpath.sv
/*
 * cache datapath: tag and data arrays, request, refill and evict registers,
 * write merge, read word select and memory request assembly
 */
`timescale 1ns/1ps
`default_nettype none

module cache_dpath
  import cache_pkg::*;
#(
  parameter int p_num_sets = 256
) (
  input  wire logic                          clk,
  input  wire logic                          reset,
  input  wire cache_req_t                    req_msg,
  input  wire mem_resp_t                     mem_resp_msg,
  input  wire way_ctrl_t                     ctl,
  input  wire logic                          way_sel,
  output cache_resp_t                        resp_msg,
  output mem_req_t                           mem_req_msg,
  output req_type_e                          req_type,
  output logic [$clog2(p_num_sets)-1:0]      idx,
  output logic                               tag_match0,
  output logic                               tag_match1
);

  localparam int idx_w = $clog2(p_num_sets);

  // two ways, combinational read, write on the edge
  line_addr_t tag_arr  [2][p_num_sets];
  line_t      data_arr [2][p_num_sets];

  cache_req_t req_reg;
  line_t      refill_line;
  line_t      evict_line;
  line_addr_t evict_addr;
  word_t      rd_word_reg;

  line_addr_t req_line;
  word_off_t  req_off;
  line_t      sel_line;
  line_t      wr_line;
  word_t      rd_word;

  // ---------------------------------------------------------------------
  // request register and address split
  // ---------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (ctl.req_en) begin
      req_reg <= req_msg;
    end
  end

  assign req_line = req_reg.addr[31:4];
  assign req_off  = req_reg.addr[3:2];
  assign req_type = req_reg.typ;

  assign idx = ctl.idx_sel ? req_msg.addr[idx_w+3:4] : req_reg.addr[idx_w+3:4];

  // tag compare against both ways
  assign tag_match0 = (tag_arr[0][idx] == req_line);
  assign tag_match1 = (tag_arr[1][idx] == req_line);

  assign sel_line = data_arr[way_sel][idx];

  // ---------------------------------------------------------------------
  // write merge and array update
  // ---------------------------------------------------------------------

  always_comb begin
    wr_line = ctl.wdata_sel ? refill_line : sel_line;
    // writes and inits drop their word into the line
    if (req_reg.typ != req_read) begin
      wr_line[{req_off, 5'd0} +: 32] = req_reg.data;
    end
  end

  always_ff @(posedge clk) begin
    if (ctl.tag_we) begin
      tag_arr[way_sel][idx] <= req_line;
    end
    if (ctl.data_we) begin
      data_arr[way_sel][idx] <= wr_line;
    end
  end

  // refill and evict capture
  always_ff @(posedge clk) begin
    if (ctl.refill_en) begin
      refill_line <= mem_resp_msg.data;
    end
    if (ctl.evict_en) begin
      evict_line <= sel_line;
      evict_addr <= tag_arr[way_sel][idx];
    end
  end

  // ---------------------------------------------------------------------
  // memory request
  // ---------------------------------------------------------------------

  always_comb begin
    if (ctl.maddr_sel) begin
      mem_req_msg.typ  = mem_write;
      mem_req_msg.addr = evict_addr;
      mem_req_msg.data = evict_line;
    end else begin
      mem_req_msg.typ  = mem_read;
      mem_req_msg.addr = req_line;
      mem_req_msg.data = '0;
    end
  end

  // ---------------------------------------------------------------------
  // read word and response
  // ---------------------------------------------------------------------

  assign rd_word = sel_line[{req_off, 5'd0} +: 32];

  // holds the word while the response is stalled
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_word_reg <= '0;
    end else if (ctl.rd_en) begin
      rd_word_reg <= rd_word;
    end
  end

  always_comb begin
    resp_msg.typ  = req_reg.typ;
    resp_msg.data = '0;
    if (req_reg.typ == req_read) begin
      resp_msg.data = ctl.rd_byp ? rd_word : rd_word_reg;
    end
  end

endmodule

`default_nettype wire

//--- hdl/cache_meta.sv
/*
 * cache metadata: valid, dirty and use bits per set,
 * hit detection and the way choice for hit, evict and refill
 */
`timescale 1ns/1ps
`default_nettype none

module cache_meta
  import cache_pkg::*;
#(
  parameter int p_num_sets = 256
) (
  input  wire logic                          clk,
  input  wire logic                          reset,
  input  wire logic [$clog2(p_num_sets)-1:0] idx,
  input  wire logic                          tag_match0,
  input  wire logic                          tag_match1,
  input  wire req_type_e                     req_type,
  input  wire ctrl_state_e                   state,
  input  wire way_ctrl_t                     ctl,
  output logic                               hit,
  output logic                               victim_dirty,
  output logic                               way_sel
);

  logic [1:0][p_num_sets-1:0] valid_bits;
  logic [1:0][p_num_sets-1:0] dirty_bits;
  // last way used per set
  logic [p_num_sets-1:0]      use_bits;
  logic                       hit0;
  logic                       hit1;
  logic                       way_tc;
  logic                       way_reg;

  // ---------------------------------------------------------------------
  // hit and way choice
  // ---------------------------------------------------------------------

  assign hit0 = valid_bits[0][idx] && tag_match0;
  assign hit1 = valid_bits[1][idx] && tag_match1;
  assign hit  = hit0 || hit1;

  always_comb begin
    if (req_type == req_init) way_tc = 1'b0;
    else if (hit0)            way_tc = 1'b0;
    else if (hit1)            way_tc = 1'b1;
    // miss replaces the way not used last
    else                      way_tc = ~use_bits[idx];
  end

  // keep the choice for the evict, refill and response states
  always_ff @(posedge clk) begin
    if (ctl.tc_en) begin
      way_reg <= way_tc;
    end
  end

  assign way_sel      = (state == st_tag_check) ? way_tc : way_reg;
  assign victim_dirty = dirty_bits[way_sel][idx];

  // ---------------------------------------------------------------------
  // state bits
  // ---------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_bits <= '0;
      dirty_bits <= '0;
      use_bits   <= '1;
    end else begin
      // a tag write always brings a line in
      if (ctl.tag_we) begin
        valid_bits[way_sel][idx] <= 1'b1;
      end
      if (ctl.dirty_we) begin
        dirty_bits[way_sel][idx] <= ctl.dirty_val;
      end
      if (ctl.use_we) begin
        use_bits[idx] <= way_sel;
      end
    end
  end

  // a line lives in one way only
  a_one_way_hit: assert property (@(posedge clk) disable iff (reset)
    (state == st_tag_check) |-> !(hit0 && hit1));

endmodule

`default_nettype wire

//--- hdl/cache_pkg.sv
/*
 * cache package: widths, request and response messages, memory messages,
 * controller states and the control bundle shared by the cache blocks
 */
`default_nettype none

package cache_pkg;

  // widths with a meaning
  typedef logic [31:0]  addr_t;
  typedef logic [31:0]  word_t;
  typedef logic [127:0] line_t;
  // line address doubles as the stored tag
  typedef logic [27:0]  line_addr_t;
  typedef logic [1:0]   word_off_t;

  typedef enum logic [1:0] {
    req_read  = 2'd0,
    req_write = 2'd1,
    req_init  = 2'd2
  } req_type_e;

  typedef enum logic {
    mem_read  = 1'b0,
    mem_write = 1'b1
  } mem_type_e;

  // ---------------------------------------------------------------------
  // stream messages
  // ---------------------------------------------------------------------

  typedef struct packed {
    req_type_e typ;
    addr_t     addr;
    word_t     data;
  } cache_req_t;

  // data is zero for write and init
  typedef struct packed {
    req_type_e typ;
    word_t     data;
  } cache_resp_t;

  typedef struct packed {
    mem_type_e  typ;
    line_addr_t addr;
    line_t      data;
  } mem_req_t;

  typedef struct packed {
    mem_type_e typ;
    line_t     data;
  } mem_resp_t;

  typedef enum logic [3:0] {
    st_idle          = 4'd0,
    st_tag_check     = 4'd1,
    st_init_wr       = 4'd2,
    st_hit_wr_sent   = 4'd3,
    st_hit_wr_wait   = 4'd4,
    st_resp_wait     = 4'd5,
    st_refill_req    = 4'd6,
    st_refill_wait   = 4'd7,
    st_refill_update = 4'd8,
    st_evict_prep    = 4'd9,
    st_evict_req     = 4'd10,
    st_evict_wait    = 4'd11,
    st_miss_rd       = 4'd12,
    st_miss_wr       = 4'd13
  } ctrl_state_e;

  // controller to metadata and datapath
  typedef struct packed {
    logic tag_we;
    logic data_we;
    logic dirty_we;
    logic dirty_val;
    logic use_we;
    logic tc_en;
    logic req_en;
    logic refill_en;
    logic evict_en;
    // 1: live request address, 0: request register
    logic idx_sel;
    // 1: refill line, 0: selected way's line
    logic wdata_sel;
    // 1: evict address (write), 0: request line (read)
    logic maddr_sel;
    logic rd_en;
    // 1: word straight from the array, 0: read word register
    logic rd_byp;
  } way_ctrl_t;

endpackage

`default_nettype wire

//--- hdl/cache_top.sv
/*
 * two-way write-back cache top: controller, metadata and datapath
 * between the processor and memory val/rdy streams
 */
`timescale 1ns/1ps
`default_nettype none

module cache_top
  import cache_pkg::*;
#(
  parameter int p_num_sets = 256
) (
  input  wire logic        clk,
  input  wire logic        reset,
  input  wire logic        req_val,
  input  wire logic        resp_rdy,
  input  wire logic        mem_req_rdy,
  input  wire logic        mem_resp_val,
  input  wire cache_req_t  req_msg,
  input  wire mem_resp_t   mem_resp_msg,
  output logic             req_rdy,
  output logic             resp_val,
  output logic             mem_req_val,
  output logic             mem_resp_rdy,
  output cache_resp_t      resp_msg,
  output mem_req_t         mem_req_msg
);

  way_ctrl_t                     ctl;
  ctrl_state_e                   state;
  req_type_e                     req_type;
  logic                          hit;
  logic                          victim_dirty;
  logic                          way_sel;
  logic [$clog2(p_num_sets)-1:0] idx;
  logic                          tag_match0;
  logic                          tag_match1;

  cache_ctrl ctrl0 (
    .clk          (clk),
    .reset        (reset),
    .req_val      (req_val),
    .resp_rdy     (resp_rdy),
    .mem_req_rdy  (mem_req_rdy),
    .mem_resp_val (mem_resp_val),
    .req_type     (req_type),
    .hit          (hit),
    .victim_dirty (victim_dirty),
    .req_rdy      (req_rdy),
    .resp_val     (resp_val),
    .mem_req_val  (mem_req_val),
    .mem_resp_rdy (mem_resp_rdy),
    .ctl          (ctl),
    .state        (state)
  );

  cache_meta #(.p_num_sets(p_num_sets)) meta0 (
    .clk          (clk),
    .reset        (reset),
    .idx          (idx),
    .tag_match0   (tag_match0),
    .tag_match1   (tag_match1),
    .req_type     (req_type),
    .state        (state),
    .ctl          (ctl),
    .hit          (hit),
    .victim_dirty (victim_dirty),
    .way_sel      (way_sel)
  );

  cache_dpath #(.p_num_sets(p_num_sets)) dpath0 (
    .clk          (clk),
    .reset        (reset),
    .req_msg      (req_msg),
    .mem_resp_msg (mem_resp_msg),
    .ctl          (ctl),
    .way_sel      (way_sel),
    .resp_msg     (resp_msg),
    .mem_req_msg  (mem_req_msg),
    .req_type     (req_type),
    .idx          (idx),
    .tag_match0   (tag_match0),
    .tag_match1   (tag_match1)
  );

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build the cache testbench with Verilator, run it, and fail on a reported failure
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module cache_tb -Mdir obj_dir -f cache.f

./obj_dir/Vcache_tb | tee sim.log

if grep -q "Test FAILED" sim.log; then
  exit 1
fi
exit 0

//--- tb/cache_tb.sv
/*
 * cache testbench: directed and random requests checked against
 * a word-map reference, with line traffic logged by the memory model
 */
`timescale 1ns/1ps
`default_nettype none

module cache_tb
  import cache_pkg::*;
();

  localparam int n_random       = 300;
  localparam int n_directed     = 40;
  // evict plus refill with full memory delays and stalls fits well inside this
  localparam int max_req_cycles = 60;

  logic        clk;
  logic        reset;
  logic        req_val;
  logic        req_rdy;
  cache_req_t  req_msg;
  logic        resp_val;
  logic        resp_rdy;
  cache_resp_t resp_msg;
  logic        mem_req_val;
  logic        mem_req_rdy;
  mem_req_t    mem_req_msg;
  logic        mem_resp_val;
  logic        mem_resp_rdy;
  mem_resp_t   mem_resp_msg;
  logic        stall_en;

  // words written or inited so far, keyed by word address
  word_t       mem_map [addr_t];
  cache_resp_t exp_q [$];
  string       name_q [$];
  int          resp_cycle [$];
  string       test_name;
  logic [31:0] rnd;
  int          cycle = 0;
  int          checks = 0;
  int          errors = 0;
  int          test_errors = 0;
  // response seen stalled on the previous cycle
  cache_resp_t held_msg;
  logic        held = 1'b0;

  cache_top #(.p_num_sets(4)) dut0 (
    .clk          (clk),
    .reset        (reset),
    .req_val      (req_val),
    .resp_rdy     (resp_rdy),
    .mem_req_rdy  (mem_req_rdy),
    .mem_resp_val (mem_resp_val),
    .req_msg      (req_msg),
    .mem_resp_msg (mem_resp_msg),
    .req_rdy      (req_rdy),
    .resp_val     (resp_val),
    .mem_req_val  (mem_req_val),
    .mem_resp_rdy (mem_resp_rdy),
    .resp_msg     (resp_msg),
    .mem_req_msg  (mem_req_msg)
  );

  cache_tb_mem mem0 (
    .clk          (clk),
    .reset        (reset),
    .stall_en     (stall_en),
    .mem_req_val  (mem_req_val),
    .mem_req_msg  (mem_req_msg),
    .mem_resp_rdy (mem_resp_rdy),
    .mem_req_rdy  (mem_req_rdy),
    .mem_resp_val (mem_resp_val),
    .mem_resp_msg (mem_resp_msg),
    .resp_rdy     (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  // ---------------------------------------------------------------------
  // reference model and helpers
  // ---------------------------------------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic word_t ref_word(input addr_t addr);
    addr_t wa;
    wa = {addr[31:2], 2'b00};
    if (mem_map.exists(wa)) begin
      return mem_map[wa];
    end
    return wa ^ 32'h5a5a0000;
  endfunction

  // expected response, writes and inits update the map
  function automatic cache_resp_t ref_resp(input req_type_e typ, input addr_t addr,
                                           input word_t data);
    cache_resp_t resp;
    resp.typ  = typ;
    resp.data = '0;
    if (typ == req_read) begin
      resp.data = ref_word(addr);
    end else begin
      mem_map[{addr[31:2], 2'b00}] = data;
    end
    return resp;
  endfunction

  function automatic line_t ref_line(input line_addr_t la);
    line_t line;
    for (int w = 0; w < 4; w++) begin
      line[w*32 +: 32] = ref_word({la, 2'(w), 2'b00});
    end
    return line;
  endfunction

  function automatic mem_req_t mem_req_of(input mem_type_e typ, input line_addr_t la,
                                          input line_t data);
    mem_req_t req;
    req.typ  = typ;
    req.addr = la;
    req.data = data;
    return req;
  endfunction

  task automatic check_value(input string name, input logic [159:0] expected,
                             input logic [159:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("error %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic check_mem_count(input int expected);
    check_value(test_name, expected, mem0.req_log.size());
  endtask

  task automatic check_mem_entry(input int idx, input mem_req_t expected);
    check_value(test_name, expected, mem0.req_log[idx]);
  endtask

  // called 1 ns after a rising edge, returns 1 ns after the transfer edge
  task automatic send_req(input req_type_e typ, input addr_t addr, input word_t data);
    exp_q.push_back(ref_resp(typ, addr, data));
    name_q.push_back(test_name);
    req_msg.typ  = typ;
    req_msg.addr = addr;
    req_msg.data = data;
    req_val      = 1'b1;
    @(negedge clk);
    while (!req_rdy) @(negedge clk);
    @(posedge clk);
    #1;
    req_val = 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0) @(posedge clk);
    @(posedge clk);
    #1;
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = errors;
  endtask

  task automatic end_test();
    $display("%s finished, %0d errors", test_name, errors - test_errors);
  endtask

  // responses arrive in request order, sampled before the transfer edge
  always @(negedge clk) begin
    if (!reset && resp_val && resp_rdy) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("a response arrived with no request outstanding");
      end else begin
        check_value(name_q.pop_front(), exp_q.pop_front(), resp_msg);
        resp_cycle.push_back(cycle);
      end
    end
  end

  // a stalled response stays put and blocks new requests
  always @(negedge clk) begin
    if (!reset && held) begin
      check_value("resp_hold", {1'b1, held_msg}, {resp_val, resp_msg});
    end
    if (!reset && resp_val && !resp_rdy) begin
      check_value("resp_hold", 0, req_rdy);
      held_msg = resp_msg;
      held     = 1'b1;
    end else begin
      held = 1'b0;
    end
  end

  initial begin : watchdog
    repeat ((n_random + n_directed) * max_req_cycles) @(posedge clk);
    $display("timeout: the cache stopped answering after %0d checks", checks);
    $display("Test FAILED");
    $finish;
  end

  // ---------------------------------------------------------------------
  // tests
  // ---------------------------------------------------------------------

  initial begin : main
    int    mark;
    int    n;
    int    kind;
    int    tag;
    int    set_idx;
    int    word;
    int    base;
    addr_t addr;
    req_val  = 1'b0;
    req_msg  = '0;
    reset    = 1'b1;
    stall_en = 1'b1;
    rnd      = 32'h2811;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;

    // idle after reset: ready for requests, nothing else active
    start_test("reset_state");
    check_value(test_name, 4'b1000, {req_rdy, resp_val, mem_req_val, mem_resp_rdy});
    end_test();

    // first touch of a line reads it once, never writes
    start_test("cold_read");
    mark = mem0.req_log.size();
    send_req(req_read, 32'h0000_1000, '0);
    drain();
    check_mem_count(mark + 1);
    check_mem_entry(mark, mem_req_of(mem_read, 28'h100, '0));
    send_req(req_read, 32'h0000_2010, '0);
    send_req(req_read, 32'h0000_1004, '0);
    drain();
    check_mem_count(mark + 2);
    check_mem_entry(mark + 1, mem_req_of(mem_read, 28'h201, '0));
    end_test();

    start_test("write_read");
    mark = mem0.req_log.size();
    send_req(req_write, 32'h0000_1008, 32'hcafe_0008);
    send_req(req_read, 32'h0000_1008, '0);
    send_req(req_read, 32'h0000_100c, '0);
    drain();
    check_mem_count(mark);
    end_test();

    // lines 302, 312 and 322 share set 2
    start_test("evict_victim");
    send_req(req_write, 32'h0000_3020, 32'h1111_0000);
    send_req(req_write, 32'h0000_3124, 32'h2222_0004);
    // reading 302 again leaves 312 as the least recent line
    send_req(req_read, 32'h0000_3020, '0);
    drain();
    mark = mem0.req_log.size();
    send_req(req_read, 32'h0000_3228, '0);
    drain();
    check_mem_count(mark + 2);
    check_mem_entry(mark, mem_req_of(mem_write, 28'h312, ref_line(28'h312)));
    check_mem_entry(mark + 1, mem_req_of(mem_read, 28'h322, '0));
    end_test();

    start_test("init_no_refill");
    mark = mem0.req_log.size();
    send_req(req_init, 32'h0000_4030, 32'h3333_0000);
    send_req(req_read, 32'h0000_4030, '0);
    drain();
    check_mem_count(mark);
    end_test();

    // init fills way 0 as a clean line without refill, so set 3 carries
    // only inits and each init word is read back at once
    start_test("random_mix");
    n = 0;
    while (n < n_random) begin
      rnd     = xorshift32(rnd);
      kind    = int'(rnd[7:0]) % 10;
      tag     = int'(rnd[9:8]);
      set_idx = int'(rnd[11:10]) % 3;
      word    = int'(rnd[13:12]);
      if (kind < 8) begin
        addr = 32'h0001_0000 + tag * 64 + set_idx * 16 + word * 4;
        rnd  = xorshift32(rnd);
        if (kind < 5) begin
          send_req(req_read, addr, '0);
        end else begin
          send_req(req_write, addr, rnd);
        end
        n++;
      end else begin
        addr = 32'h0002_0000 + tag * 64 + 48 + word * 4;
        rnd  = xorshift32(rnd);
        send_req(req_init, addr, rnd);
        send_req(req_read, addr, '0);
        n += 2;
      end
    end
    drain();
    end_test();

    // warm two lines, then stream hits with the response side always ready
    start_test("read_hit_stream");
    stall_en = 1'b0;
    send_req(req_read, 32'h0000_1000, '0);
    send_req(req_read, 32'h0000_2010, '0);
    drain();
    mark = mem0.req_log.size();
    for (int i = 0; i < 8; i++) begin
      addr = ((i % 2 == 0) ? 32'h0000_1000 : 32'h0000_2010) + (i / 2) * 4;
      send_req(req_read, addr, '0);
    end
    drain();
    check_mem_count(mark);
    base = resp_cycle.size() - 8;
    for (int i = 1; i < 8; i++) begin
      check_value(test_name, 1, resp_cycle[base + i] - resp_cycle[base + i - 1]);
    end
    end_test();

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/cache_tb_mem.sv
/*
 * memory model for the cache testbench: answers line reads and writes
 * after random delays, logs every request and stalls the response ready
 */
`timescale 1ns/1ps
`default_nettype none

module cache_tb_mem
  import cache_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      reset,
  input  wire logic      stall_en,
  input  wire logic      mem_req_val,
  input  wire mem_req_t  mem_req_msg,
  input  wire logic      mem_resp_rdy,
  output logic           mem_req_rdy,
  output logic           mem_resp_val,
  output mem_resp_t      mem_resp_msg,
  output logic           resp_rdy
);

  // lines written back so far, untouched lines come from the fill pattern
  line_t       lines [line_addr_t];
  // every accepted request in arrival order
  mem_req_t    req_log [$];
  mem_req_t    req;
  logic [31:0] delay_rnd;
  logic [31:0] stall_rnd;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // each word holds its own byte address xor a marker
  function automatic line_t fill_line(input line_addr_t la);
    line_t line;
    for (int w = 0; w < 4; w++) begin
      line[w*32 +: 32] = {la, 2'(w), 2'b00} ^ 32'h5a5a0000;
    end
    return line;
  endfunction

  // ---------------------------------------------------------------------
  // one request at a time, ready and response each 0 to 3 cycles late
  // ---------------------------------------------------------------------

  initial begin : serve
    mem_req_rdy  = 1'b0;
    mem_resp_val = 1'b0;
    mem_resp_msg = '0;
    req          = '0;
    delay_rnd    = 32'h2811;
    forever begin
      @(negedge clk);
      if (!reset && mem_req_val) begin
        @(posedge clk);
        #1;
        delay_rnd = xorshift32(delay_rnd);
        repeat (delay_rnd[1:0]) begin
          @(posedge clk);
          #1;
        end
        mem_req_rdy = 1'b1;
        // request is held until ready, so the negedge sees the final message
        @(negedge clk);
        req = mem_req_msg;
        req_log.push_back(req);
        @(posedge clk);
        #1;
        mem_req_rdy      = 1'b0;
        mem_resp_msg.typ = req.typ;
        if (req.typ == mem_write) begin
          lines[req.addr]   = req.data;
          mem_resp_msg.data = '0;
        end else if (lines.exists(req.addr)) begin
          mem_resp_msg.data = lines[req.addr];
        end else begin
          mem_resp_msg.data = fill_line(req.addr);
        end
        repeat (delay_rnd[3:2]) begin
          @(posedge clk);
          #1;
        end
        mem_resp_val = 1'b1;
        @(negedge clk);
        while (!mem_resp_rdy) @(negedge clk);
        @(posedge clk);
        #1;
        mem_resp_val = 1'b0;
      end
    end
  end

  // processor side back-pressure, about one cycle in four
  initial begin : stall
    resp_rdy  = 1'b1;
    stall_rnd = 32'h2811;
    forever begin
      @(posedge clk);
      #1;
      stall_rnd = xorshift32(stall_rnd);
      resp_rdy  = !stall_en || (stall_rnd[1:0] != 2'b00);
    end
  end

endmodule

`default_nettype wire
